// File: compile.f
+incdir+include
source/icache_pkg.sv
source/icache_tag_array.sv
source/icache_data_array.sv
source/icache_refill_buf.sv
source/icache_ctrl.sv
source/icache_top.sv
tb/icache_mem_model.sv
tb/tb_icache_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the instruction cache testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  -f compile.f \
  --top-module tb_icache_top \
  -o sim_icache

./obj_dir/sim_icache 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi

echo "simulation finished without failures"

// File: tb/icache_testdata.txt
// columns: op (0 fetch, 1 invalidate), group, address, expected word, expected hit
// groups: 1 cold miss, 2 hit, 3 conflict, 4 invalidate, 5 reset miss, 6 refill latency
0 5 00000000 5a5a0000 0
0 1 00000014 5a5a0014 0
0 1 00000028 5a5a0028 0
0 1 0000003c 5a5a003c 0
0 1 12345670 486e5670 0
// all four offsets of line 1, back to back
0 2 00000010 5a5a0010 1
0 2 00000014 5a5a0014 1
0 2 00000018 5a5a0018 1
0 2 0000001c 5a5a001c 1
0 2 0000001c 5a5a001c 1
0 2 00000010 5a5a0010 1
// index 2 with tags 0 and 1
0 3 00000228 5a5a0228 0
0 3 0000022c 5a5a022c 1
0 3 00000028 5a5a0028 0
0 3 00000020 5a5a0020 1
0 3 00000220 5a5a0220 0
0 4 00000000 5a5a0000 1
1 4 00000000 00000000 0
0 4 00000000 5a5a0000 0
0 4 00000004 5a5a0004 1
0 4 00000014 5a5a0014 0
// refills that start at high and low beat offsets
0 6 80001008 da5a1008 0
0 6 80001000 da5a1000 1
0 6 80001004 da5a1004 1
0 6 8000100c da5a100c 1
0 6 80001008 da5a1008 1
0 6 7ffff0f4 25a5f0f4 0
0 6 7ffff0f0 25a5f0f0 1
0 6 7ffff0f8 25a5f0f8 1
0 6 7ffff0fc 25a5f0fc 1
0 6 fffffff0 a5a5fff0 0
0 6 fffffffc a5a5fffc 1
0 6 fffffff8 a5a5fff8 1
0 6 fffffff4 a5a5fff4 1
0 6 0000013c 5a5a013c 0
0 6 00000130 5a5a0130 1
0 6 00000138 5a5a0138 1

// File: tb/tb_icache_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_icache_top
  import icache_pkg::*;
();

  localparam int          MAX_OPS  = 64;
  localparam int          FIELDS   = 5;  // op, group, address, word, hit
  localparam logic [31:0] END_MARK = 32'hFFFF_FFFF;

  logic       clk;
  logic       rst;
  fetch_req_t fetch_req;
  logic       flush;
  mem_rsp_t   mem_rsp;
  fetch_rsp_t fetch_rsp;
  mem_req_t   mem_req;

  logic [31:0] ops [MAX_OPS*FIELDS];
  int          n_ops;
  int          word_errs;
  int          hit_errs;
  int          addr_errs;
  int          other_errs;
  int          cycles = 0;
  int          cycle_limit = MAX_OPS * 20 + 100;

  icache_top u_icache_top (
    .clk         (clk),
    .rst         (rst),
    .fetch_req_i (fetch_req),
    .flush_i     (flush),
    .mem_rsp_i   (mem_rsp),
    .fetch_rsp_o (fetch_rsp),
    .mem_req_o   (mem_req)
  );

  icache_mem_model u_icache_mem_model (
    .clk       (clk),
    .rst       (rst),
    .mem_req_i (mem_req),
    .mem_rsp_o (mem_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // run limit, tightened once the operations are counted
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("ERROR: timeout, the cache gave no response within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  function automatic string group_name(input logic [31:0] grp);
    case (grp)
      1: return "cold_miss";
      2: return "hit";
      3: return "conflict";
      4: return "invalidate";
      5: return "reset_miss";
      6: return "refill_latency";
      default: return "unnamed";
    endcase
  endfunction

  task automatic compare_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("MISMATCH %s word: expected %h, actual %h", name, exp, act);
      word_errs++;
    end
  endtask

  task automatic compare_hit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("MISMATCH %s hit: expected %0b, actual %0b", name, exp, act);
      hit_errs++;
    end
  endtask

  task automatic compare_addr(input string name, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      $display("MISMATCH %s memory address: expected %h, actual %h", name, exp, act);
      addr_errs++;
    end
  endtask

  // holds the request until the response pulse, returns on that falling edge
  task automatic fetch_word(input string name, input addr_t addr, output word_t word,
                            output logic hit);
    logic  saw_mem;
    logic  lo_seen;
    addr_t base;
    saw_mem         = 1'b0;
    lo_seen         = 1'b0;
    base            = addr & 32'hFFFF_FFF0;  // 16-byte line base
    fetch_req.addr  = addr;
    fetch_req.valid = 1'b1;
    do begin
      @(negedge clk);
      if (mem_req.valid) begin
        saw_mem = 1'b1;  // line was refilled
        // low beat at the line base, high beat 8 bytes above
        compare_addr(name, lo_seen ? base + 32'd8 : base, mem_req.addr);
        if (mem_rsp.ready) begin
          lo_seen = 1'b1;
        end
      end
    end while (!fetch_rsp.valid);
    word = fetch_rsp.word;
    hit  = !saw_mem;
  endtask

  task automatic flush_cache();
    fetch_req.valid = 1'b0;
    flush           = 1'b1;
    @(negedge clk);
    flush           = 1'b0;
  endtask

  task automatic check_quiet(input int n);
    repeat (n) begin
      @(negedge clk);
      if (mem_req.valid || fetch_rsp.valid) begin
        $display("ERROR: memory request or fetch response active before any fetch");
        other_errs++;
      end
    end
  endtask

  initial begin
    int          i;
    logic [31:0] op;
    logic [31:0] grp;
    addr_t       addr;
    word_t       exp_word;
    logic        exp_hit;
    word_t       got_word;
    logic        got_hit;
    string       name;

    rst        = 1'b1;
    fetch_req  = '0;
    flush      = 1'b0;
    word_errs  = 0;
    hit_errs   = 0;
    addr_errs  = 0;
    other_errs = 0;

    for (i = 0; i < MAX_OPS * FIELDS; i++) begin
      ops[i] = END_MARK;
    end
    $readmemh("tb/icache_testdata.txt", ops);
    n_ops = 0;
    while (n_ops < MAX_OPS && ops[n_ops * FIELDS] != END_MARK) begin
      n_ops++;
    end
    cycle_limit = n_ops * 20 + 100;
    if (n_ops == 0) begin
      $display("ERROR: the test data file holds no operations");
      other_errs++;
    end

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_quiet(3);

    for (i = 0; i < n_ops; i++) begin
      op       = ops[i * FIELDS];
      grp      = ops[i * FIELDS + 1];
      addr     = ops[i * FIELDS + 2];
      exp_word = ops[i * FIELDS + 3];
      exp_hit  = ops[i * FIELDS + 4][0];
      name     = $sformatf("%s op %0d", group_name(grp), i);
      if (op == 32'd0) begin
        fetch_word(name, addr, got_word, got_hit);
        compare_word(name, exp_word, got_word);
        compare_hit(name, exp_hit, got_hit);
      end else if (op == 32'd1) begin
        flush_cache();
      end else begin
        $display("ERROR: unknown operation code %0h in the test data at op %0d", op, i);
        other_errs++;
      end
    end

    fetch_req.valid = 1'b0;
    @(negedge clk);
    if (fetch_rsp.valid) begin
      $display("ERROR: fetch response stayed valid for more than one cycle");
      other_errs++;
    end

    $display("errors: word %0d, hit %0d, address %0d, other %0d",
             word_errs, hit_errs, addr_errs, other_errs);
    if (word_errs + hit_errs + addr_errs + other_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/icache_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module icache_mem_model
  import icache_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire mem_req_t mem_req_i,
  output mem_rsp_t      mem_rsp_o
);

  int unsigned wait_q;    // cycles waited for the current beat
  int unsigned target_q;  // latency drawn for the current beat

  // every aligned word holds its own address, scrambled
  function automatic word_t word_at(input addr_t a);
    return a ^ 32'h5A5A_0000;
  endfunction

  // lower address in the low half of the beat
  function automatic beat_t beat_at(input addr_t a);
    addr_t base;
    base = {a[31:3], 3'b000};
    return {word_at(base + 32'd4), word_at(base)};
  endfunction

  initial begin
    void'($urandom(22));  // one seed for the whole run
    mem_rsp_o = '0;
    wait_q    = 0;
    target_q  = 1 + $urandom % 4;
    forever begin
      @(posedge clk);
      if (rst) begin
        mem_rsp_o <= '0;
        wait_q    <= 0;
        target_q  <= 1 + $urandom % 4;
      end else begin
        mem_rsp_o.ready <= 1'b0;  // ready is a one-cycle pulse
        // skip the cycle in which the beat is being taken
        if (mem_req_i.valid && !mem_rsp_o.ready) begin
          if (wait_q + 1 >= target_q) begin
            mem_rsp_o.ready <= 1'b1;
            mem_rsp_o.data  <= beat_at(mem_req_i.addr);
            wait_q          <= 0;
            target_q        <= 1 + $urandom % 4;  // next beat latency
          end else begin
            wait_q <= wait_q + 1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/icache_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_cfg.svh"

module icache_top
  import icache_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire fetch_req_t fetch_req_i,
  input  wire logic       flush_i,
  input  wire mem_rsp_t   mem_rsp_i,
  output fetch_rsp_t      fetch_rsp_o,
  output mem_req_t        mem_req_o
);

  logic  hit;
  word_t rd_word;
  word_t refill_word;
  line_t refill_line;
  addr_t lookup_addr;
  logic  line_we;
  logic  capture_lo;
  logic  invalidate;

  icache_ctrl u_icache_ctrl (
    .clk           (clk),
    .rst           (rst),
    .fetch_req_i   (fetch_req_i),
    .flush_i       (flush_i),
    .hit_i         (hit),
    .rd_word_i     (rd_word),
    .mem_rsp_i     (mem_rsp_i),
    .refill_word_i (refill_word),
    .fetch_rsp_o   (fetch_rsp_o),
    .mem_req_o     (mem_req_o),
    .lookup_addr_o (lookup_addr),
    .line_we_o     (line_we),
    .capture_lo_o  (capture_lo),
    .invalidate_o  (invalidate)
  );

  icache_tag_array u_icache_tag_array (
    .clk           (clk),
    .rst           (rst),
    .lookup_addr_i (lookup_addr),
    .line_we_i     (line_we),
    .invalidate_i  (invalidate),
    .hit_o         (hit)
  );

  icache_data_array u_icache_data_array (
    .clk           (clk),
    .lookup_addr_i (lookup_addr),
    .line_we_i     (line_we),
    .line_i        (refill_line),
    .word_o        (rd_word)
  );

  // offset comes from the latched request during refill
  icache_refill_buf u_icache_refill_buf (
    .clk          (clk),
    .rst          (rst),
    .mem_rsp_i    (mem_rsp_i),
    .capture_lo_i (capture_lo),
    .offset_i     (lookup_addr[`ICACHE_OFFSET_W-1:0]),
    .line_o       (refill_line),
    .word_o       (refill_word)
  );

endmodule

`default_nettype wire

// File: source/icache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_cfg.svh"

module icache_ctrl
  import icache_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire fetch_req_t fetch_req_i,
  input  wire logic       flush_i,
  input  wire logic       hit_i,
  input  wire word_t      rd_word_i,
  input  wire mem_rsp_t   mem_rsp_i,
  input  wire word_t      refill_word_i,
  output fetch_rsp_t      fetch_rsp_o,
  output mem_req_t        mem_req_o,
  output addr_t           lookup_addr_o,
  output logic            line_we_o,
  output logic            capture_lo_o,
  output logic            invalidate_o
);

  icache_state_e state_q;

  addr_t req_addr_q;   // address of the fetch being served
  addr_t mem_addr_q;
  logic  mem_valid_q;
  logic  rsp_valid_q;
  word_t rsp_word_q;

  logic idle;
  logic take_req;
  logic beat_ok;
  logic lo_done;
  logic hi_done;

  assign idle     = (state_q == ST_IDLE);
  assign take_req = idle && fetch_req_i.valid && !flush_i;  // flush wins
  assign beat_ok  = mem_valid_q && mem_rsp_i.ready;
  assign lo_done  = (state_q == ST_MISS_LO) && beat_ok;
  assign hi_done  = (state_q == ST_MISS_HI) && beat_ok;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= ST_RESET;
      mem_valid_q <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= 1'b0;  // response is a pulse
      case (state_q)
        ST_RESET: begin
          state_q <= ST_IDLE;
        end
        ST_IDLE: begin
          if (take_req) begin
            if (hit_i) begin
              rsp_valid_q <= 1'b1;
            end else begin
              mem_valid_q <= 1'b1;
              state_q     <= ST_MISS_LO;
            end
          end
        end
        ST_MISS_LO: begin
          if (beat_ok) begin
            state_q <= ST_MISS_HI;
          end
        end
        ST_MISS_HI: begin
          if (beat_ok) begin
            mem_valid_q <= 1'b0;
            rsp_valid_q <= 1'b1;
            state_q     <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // request address, memory address and response word
  always_ff @(posedge clk) begin
    if (take_req) begin
      req_addr_q <= fetch_req_i.addr;
    end
    if (take_req && !hit_i) begin
      // line base, offset bits zero
      mem_addr_q <= {fetch_req_i.addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W],
                     {`ICACHE_OFFSET_W{1'b0}}};
    end else if (lo_done) begin
      mem_addr_q <= mem_addr_q + `ICACHE_ADDR_W'(`ICACHE_MEM_W / 8);  // upper beat
    end
    if (take_req && hit_i) begin
      rsp_word_q <= rd_word_i;
    end else if (hi_done) begin
      rsp_word_q <= refill_word_i;  // straight from the assembled line
    end
  end

  // live address for lookup in idle, latched one during refill
  assign lookup_addr_o = idle ? fetch_req_i.addr : req_addr_q;

  assign capture_lo_o = lo_done;
  assign line_we_o    = hi_done;
  assign invalidate_o = idle && flush_i;

  assign fetch_rsp_o.word  = rsp_word_q;
  assign fetch_rsp_o.valid = rsp_valid_q;
  assign mem_req_o.addr    = mem_addr_q;
  assign mem_req_o.valid   = mem_valid_q;

  // memory is quiet whenever the cache waits for a fetch
  assert property (@(posedge clk) disable iff (rst) idle |-> !mem_valid_q);

  // a second response in a row only comes from a hit, never from a refill
  assert property (@(posedge clk) disable iff (rst)
    rsp_valid_q |=> !rsp_valid_q || $past(take_req && hit_i));

endmodule

`default_nettype wire

// File: source/icache_refill_buf.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_cfg.svh"

module icache_refill_buf
  import icache_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire mem_rsp_t mem_rsp_i,
  input  wire logic     capture_lo_i,
  input  wire offset_t  offset_i,
  output line_t         line_o,
  output word_t         word_o
);

  beat_t lo_q;  // first beat of the refill

  logic [`ICACHE_WORD_SEL_W-1:0] word_sel;

  always_ff @(posedge clk) begin
    if (rst) begin
      lo_q <= '0;
    end else if (capture_lo_i) begin
      lo_q <= mem_rsp_i.data;
    end
  end

  // high beat is used live in the cycle it arrives
  assign line_o = {mem_rsp_i.data, lo_q};

  assign word_sel = offset_i[`ICACHE_OFFSET_W-1:`ICACHE_WORD_LSB];
  assign word_o   = line_o[word_sel * `ICACHE_WORD_W +: `ICACHE_WORD_W];

  // low beat is only taken when memory hands it over
  assert property (@(posedge clk) disable iff (rst) capture_lo_i |-> mem_rsp_i.ready);

endmodule

`default_nettype wire

// File: source/icache_data_array.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_cfg.svh"

module icache_data_array
  import icache_pkg::*;
(
  input  wire logic  clk,
  input  wire addr_t lookup_addr_i,
  input  wire logic  line_we_i,
  input  wire line_t line_i,
  output word_t      word_o
);

  line_t lines_q [`ICACHE_LINES];

  index_t                        idx;
  logic [`ICACHE_WORD_SEL_W-1:0] word_sel;
  line_t                         rd_line;

  assign idx      = lookup_addr_i[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
  assign word_sel = lookup_addr_i[`ICACHE_WORD_LSB +: `ICACHE_WORD_SEL_W];

  always_ff @(posedge clk) begin
    if (line_we_i) begin
      lines_q[idx] <= line_i;
    end
  end

  // combinational read, word picked by offset
  assign rd_line = lines_q[idx];
  assign word_o  = rd_line[word_sel * `ICACHE_WORD_W +: `ICACHE_WORD_W];

endmodule

`default_nettype wire

// File: source/icache_tag_array.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_cfg.svh"

module icache_tag_array
  import icache_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire addr_t lookup_addr_i,
  input  wire logic  line_we_i,
  input  wire logic  invalidate_i,
  output logic       hit_o
);

  tag_t                     tags_q [`ICACHE_LINES];
  logic [`ICACHE_LINES-1:0] valid_q;

  index_t idx;
  tag_t   tag;

  // address split
  assign idx = lookup_addr_i[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
  assign tag = lookup_addr_i[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

  assign hit_o = valid_q[idx] && (tags_q[idx] == tag);

  // valid bits, flash cleared
  always_ff @(posedge clk) begin
    if (rst || invalidate_i) begin
      valid_q <= '0;
    end else if (line_we_i) begin
      valid_q[idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (line_we_i) begin
      tags_q[idx] <= tag;
    end
  end

  // refill and flush are mutually exclusive in the controller
  assert property (@(posedge clk) disable iff (rst) !(line_we_i && invalidate_i));

endmodule

`default_nettype wire

// File: source/icache_pkg.sv
`default_nettype none

`include "icache_cfg.svh"

package icache_pkg;

  typedef logic [`ICACHE_ADDR_W-1:0]   addr_t;
  typedef logic [`ICACHE_WORD_W-1:0]   word_t;
  typedef logic [`ICACHE_MEM_W-1:0]    beat_t;
  typedef logic [`ICACHE_LINE_W-1:0]   line_t;
  typedef logic [`ICACHE_TAG_W-1:0]    tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0]  index_t;
  typedef logic [`ICACHE_OFFSET_W-1:0] offset_t;

  // fetch stage -> cache
  typedef struct packed {
    addr_t addr;
    logic  valid;  // held until the response
  } fetch_req_t;

  // cache -> fetch stage
  typedef struct packed {
    word_t word;
    logic  valid;  // one-cycle pulse
  } fetch_rsp_t;

  // cache -> memory, valid spans both beats
  typedef struct packed {
    addr_t addr;
    logic  valid;
  } mem_req_t;

  // memory -> cache, one ready per beat
  typedef struct packed {
    beat_t data;
    logic  ready;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    ST_RESET,
    ST_IDLE,
    ST_MISS_LO,
    ST_MISS_HI
  } icache_state_e;

endpackage

`default_nettype wire

// File: include/icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// cache geometry
`define ICACHE_ADDR_W      32
`define ICACHE_LINE_BYTES  16
`define ICACHE_LINES       32
`define ICACHE_MEM_W       64
`define ICACHE_WORD_W      32

// derived address fields: offset 4, index 5, tag 23
`define ICACHE_LINE_W      (`ICACHE_LINE_BYTES * 8)
`define ICACHE_OFFSET_W    $clog2(`ICACHE_LINE_BYTES)
`define ICACHE_INDEX_W     $clog2(`ICACHE_LINES)
`define ICACHE_TAG_W       (`ICACHE_ADDR_W - `ICACHE_OFFSET_W - `ICACHE_INDEX_W)

// word select inside a line, byte bits below it are dropped
`define ICACHE_WORD_LSB    $clog2(`ICACHE_WORD_W / 8)
`define ICACHE_WORD_SEL_W  (`ICACHE_OFFSET_W - `ICACHE_WORD_LSB)

`endif
